// File: lc4_core.f
hdl/lc4_isa_pkg.sv
hdl/lc4_pipe_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile.sv
hdl/lc4_alu.sv
hdl/lc4_hazard_unit.sv
hdl/lc4_core.sv
test/lc4_core_checker.sv
test/lc4_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LC4 core testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module lc4_core_tb -f lc4_core.f \
   --Mdir obj_dir -o lc4_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/lc4_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
exit 0

// File: test/lc4_core_tb.sv
// ============================================================
// LC4 core testbench
// Memory models, program loader, directed tests
// ============================================================
`timescale 1ns/100ps

module lc4_core_tb;
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   localparam int PROG_SLOT = 24;                    // Max words per program
   localparam int NUM_TESTS = 5;
   localparam int CYCLE_LIMIT = NUM_TESTS * PROG_SLOT * 4 + 100;

   logic              gwe = 1'b0;
   logic              rst_n;
   logic [WORD_W-1:0] cur_insn, dmem_data, cur_pc, dmem_addr, dmem_towrite;
   logic              dmem_we;
   logic [WORD_W-1:0] imem [PROG_SLOT];
   logic [WORD_W-1:0] dmem [256];
   logic [WORD_W-1:0] log_addr[$], log_data[$], exp_addr[$], exp_data[$];
   logic [WORD_W-1:0] pc_off;
   int                plen, cycles;
   integer            seed = 32'h8061;

   always #20 gwe = ~gwe;                            // 40 ns period

   lc4_core dut_i (
      .gwe(gwe), .i_rst_n(rst_n), .i_cur_insn(cur_insn), .i_cur_dmem_data(dmem_data),
      .o_cur_pc(cur_pc), .o_dmem_addr(dmem_addr), .o_dmem_towrite(dmem_towrite),
      .o_dmem_we(dmem_we));

   // ============================================================
   // Memory models and store monitor
   // ============================================================
   assign pc_off    = cur_pc - RESET_PC;
   assign cur_insn  = (pc_off < PROG_SLOT) ? imem[pc_off] : NOP_INSN;
   assign dmem_data = dmem[dmem_addr[7:0]];          // Same-cycle read

   always @(posedge gwe) begin
      if (dmem_we === 1'b1) begin
         dmem[dmem_addr[7:0]] <= dmem_towrite;
         log_addr.push_back(dmem_addr);
         log_data.push_back(dmem_towrite);
      end
   end

   always @(posedge gwe) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, program never finished", cycles);
         $display("Result: FAILED");
         $fatal(1);
      end
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] act);
      if (act !== exp) begin
         abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // ============================================================
   // Encoders and expected-value helpers
   // ============================================================
   function automatic logic [WORD_W-1:0] sext(input logic [WORD_W-1:0] v, input int bits);
      logic signed [WORD_W-1:0] t;
      t = v << (WORD_W - bits);
      return t >>> (WORD_W - bits);
   endfunction

   function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm);
      return {OPC_CONST, rd, imm};
   endfunction

   function automatic logic [15:0] enc_arith(input logic [2:0] rd, rs, input logic [2:0] sub,
                                             input logic [2:0] rt);
      return {OPC_ARITH, rd, rs, sub, rt};
   endfunction

   function automatic logic [15:0] enc_addi(input logic [2:0] rd, rs, input logic [4:0] imm);
      return {OPC_ARITH, rd, rs, 1'b1, imm};
   endfunction

   function automatic logic [15:0] enc_mem(input logic [3:0] opc, input logic [2:0] r, rs,
                                           input logic [5:0] imm);
      return {opc, r, rs, imm};
   endfunction

   task automatic emit(input logic [15:0] insn);
      imem[plen] = insn;
      plen++;
   endtask

   task automatic new_program();
      foreach (imem[i]) imem[i] = NOP_INSN;
      plen = 0;
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic expect_store(input logic [15:0] a, input logic [15:0] d);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   // Reset pulse, then run until the expected stores are logged
   task automatic run_and_check(input string name);
      @(posedge gwe) rst_n <= 1'b0;
      repeat (8) @(posedge gwe);
      rst_n <= 1'b1;
      log_addr.delete();
      log_data.delete();
      while (log_addr.size() < exp_addr.size()) @(posedge gwe);
      repeat (10) @(posedge gwe);                    // Catch stray stores
      if (log_addr.size() != exp_addr.size()) begin
         abort_run($sformatf("%s: saw %0d stores where %0d were due", name,
                             log_addr.size(), exp_addr.size()));
      end
      foreach (exp_addr[i]) begin
         compare_word({name, " addr"}, exp_addr[i], log_addr[i]);
         compare_word({name, " data"}, exp_data[i], log_data[i]);
      end
   endtask

   // ============================================================
   // Directed tests
   // ============================================================
   task automatic test_reset();
      new_program();
      for (int k = 0; k < PROG_SLOT; k++) begin
         emit(enc_mem(OPC_STR, 3'd0, 3'd0, 6'(k)));  // Stores in flight at reset
      end
      repeat (8) @(posedge gwe);
      rst_n <= 1'b1;
      repeat (4) @(posedge gwe);
      @(negedge gwe);
      compare_bit("store before reset", 1'b1, dmem_we);
      @(posedge gwe) rst_n <= 1'b0;
      repeat (7) begin
         @(posedge gwe);
         @(negedge gwe);
         compare_word("reset pc", RESET_PC, cur_pc);
         compare_bit("reset dmem_we", 1'b0, dmem_we);
      end
      @(posedge gwe) rst_n <= 1'b1;
      @(negedge gwe);
      compare_word("release pc", RESET_PC, cur_pc);
      compare_bit("release dmem_we", 1'b0, dmem_we);
      for (int k = 1; k <= 12; k++) begin
         @(negedge gwe);
         compare_word("count pc", RESET_PC + 16'(k), cur_pc);
         if (k <= 2) compare_bit("release dmem_we", 1'b0, dmem_we);
      end
   endtask

   task automatic test_arith();
      logic [31:0] r;
      logic [15:0] a, b, s3, s4, s5;
      r = $random(seed);
      a = sext(r[8:0], 9);
      b = sext(r[17:9], 9);
      s3 = a + b;
      s4 = s3 - a;
      s5 = s4 + sext(r[22:18], 5);
      new_program();
      emit(enc_const(3'd7, 9'h040));                 // Store base
      emit(enc_const(3'd1, r[8:0]));
      emit(enc_const(3'd2, r[17:9]));
      emit(enc_arith(3'd3, 3'd1, SUB_ADD, 3'd2));    // MX and WX
      emit(enc_arith(3'd4, 3'd3, SUB_SUB, 3'd1));
      emit(enc_addi(3'd5, 3'd4, r[22:18]));
      emit(enc_mem(OPC_STR, 3'd3, 3'd7, 6'd0));
      emit(enc_mem(OPC_STR, 3'd4, 3'd7, 6'd1));
      emit(enc_mem(OPC_STR, 3'd5, 3'd7, 6'd2));
      expect_store(16'h0040, s3);
      expect_store(16'h0041, s4);
      expect_store(16'h0042, s5);
      run_and_check("arith");
   endtask

   task automatic test_load_use();
      logic [15:0] m0, m1;
      m0 = 16'($random(seed));
      m1 = 16'($random(seed));
      dmem[8'h50] = m0;
      dmem[8'h51] = m1;
      new_program();
      emit(enc_const(3'd7, 9'h050));
      emit(enc_const(3'd6, 9'h060));
      emit(enc_mem(OPC_LDR, 3'd1, 3'd7, 6'd0));
      emit(enc_arith(3'd2, 3'd1, SUB_ADD, 3'd1));    // Needs the stall
      emit(enc_mem(OPC_STR, 3'd2, 3'd6, 6'd0));
      emit(enc_mem(OPC_LDR, 3'd3, 3'd7, 6'd1));
      emit(enc_arith(3'd4, 3'd3, SUB_ADD, 3'd2));
      emit(enc_mem(OPC_STR, 3'd4, 3'd6, 6'd1));
      expect_store(16'h0060, m0 + m0);
      expect_store(16'h0061, m1 + m0 + m0);
      run_and_check("load_use");
   endtask

   task automatic test_store_bypass();
      logic [31:0] r;
      logic [15:0] a;
      r = $random(seed);
      a = sext(r[8:0], 9);
      new_program();
      emit(enc_const(3'd7, 9'h070));
      emit(enc_const(3'd1, r[8:0]));
      emit(enc_arith(3'd1, 3'd1, SUB_ADD, 3'd1));
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd0));      // New r1, not stale
      emit(enc_mem(OPC_LDR, 3'd2, 3'd7, 6'd0));
      emit(enc_mem(OPC_STR, 3'd2, 3'd7, 6'd1));      // WM path
      expect_store(16'h0070, a + a);
      expect_store(16'h0071, a + a);
      run_and_check("store_bypass");
   endtask

   task automatic test_branch();
      new_program();
      emit(enc_const(3'd7, 9'h030));
      emit(enc_const(3'd1, 9'h1fb));                 // -5, N
      emit({OPC_BR, 3'b010, 9'd1});                  // Not taken
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd0));
      emit({OPC_BR, 3'b100, 9'd1});                  // Taken, skips next
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd1));
      emit(enc_const(3'd2, 9'd0));                   // Z
      emit({OPC_BR, 3'b101, 9'd1});
      emit(enc_mem(OPC_STR, 3'd2, 3'd7, 6'd2));
      emit({OPC_JMP, 1'b1, 11'd2});                  // Over two stores
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd3));
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd4));
      emit(enc_const(3'd3, 9'd9));                   // P
      emit({OPC_BR, 3'b001, 9'd1});
      emit(enc_mem(OPC_STR, 3'd1, 3'd7, 6'd5));
      emit(enc_mem(OPC_STR, 3'd3, 3'd7, 6'd6));
      expect_store(16'h0030, 16'hfffb);
      expect_store(16'h0032, 16'h0000);
      expect_store(16'h0036, 16'h0009);
      run_and_check("branch");
   endtask

   initial begin
      rst_n = 1'b0;
      cycles = 0;
      foreach (imem[i]) imem[i] = NOP_INSN;
      foreach (dmem[i]) dmem[i] = {~i[7:0], i[7:0]};
      test_reset();
      test_arith();
      test_load_use();
      test_store_bypass();
      test_branch();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: test/lc4_core_checker.sv
// ============================================================
// LC4 core checker
// Assertions on PC flow and data memory strobes
// ============================================================
`timescale 1ns/100ps

module lc4_core_checker
   import lc4_isa_pkg::*;
(
   input logic              gwe,
   input logic              i_rst_n,
   input logic [WORD_W-1:0] pc,
   input logic [WORD_W-1:0] x_alu,         // Branch target in execute
   input logic              x_is_load,
   input logic              x_is_store,
   input logic              x_is_branch,
   input logic              x_is_jump,
   input logic [WORD_W-1:0] o_dmem_addr,
   input logic              o_dmem_we
);

   // Strobe cleared by any reset edge
   a_we_reset : assert property (@(posedge gwe) !i_rst_n |=> !o_dmem_we)
      else $error("dmem write strobe high after a reset edge");

   // Next PC is +1, a hold behind a load, or a target from a control insn
   a_pc_flow : assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_rst_n |=> (pc == $past(pc) + 16'd1) ||
                  ((pc == $past(pc)) && $past(x_is_load)) ||
                  ((pc == $past(x_alu)) && $past(x_is_branch || x_is_jump)))
      else $error("PC moved in a way no stall or branch explains");

   // Address bus idle unless a load or store left execute
   a_addr_idle : assert property (@(posedge gwe) disable iff (!i_rst_n)
      !$past(x_is_load || x_is_store) |-> o_dmem_addr == '0)
      else $error("dmem address nonzero with no memory op");

endmodule

bind lc4_core lc4_core_checker checker_i (
   .gwe(gwe), .i_rst_n(i_rst_n), .pc(pc), .x_alu(x_alu),
   .x_is_load(x_is_load), .x_is_store(x_is_store),
   .x_is_branch(x_is_branch), .x_is_jump(x_is_jump),
   .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we));

// File: hdl/lc4_core.sv
// ============================================================
// LC4 five-stage pipelined core
// Fetch, decode, execute, memory, writeback with bypass,
// load-use stall and branch squash in execute
// ============================================================
`timescale 1ns/100ps

module lc4_core
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic              gwe,
   input  logic              i_rst_n,
   input  logic [WORD_W-1:0] i_cur_insn,       // Same-cycle imem answer
   input  logic [WORD_W-1:0] i_cur_dmem_data,  // Same-cycle dmem answer
   output logic [WORD_W-1:0] o_cur_pc,
   output logic [WORD_W-1:0] o_dmem_addr,
   output logic [WORD_W-1:0] o_dmem_towrite,
   output logic              o_dmem_we
);

   // Fetch
   logic [WORD_W-1:0] pc;
   logic [WORD_W-1:0] next_pc;
   logic              pc_we;
   // Decode
   lc4_insn_u            d_insn;
   logic [WORD_W-1:0]    d_pc;
   logic [REG_SEL_W-1:0] d_rs_sel, d_rt_sel, d_rd_sel;
   logic                 d_rs_re, d_rt_re, d_regfile_we, d_nzp_we;
   logic                 d_is_load, d_is_store, d_is_branch, d_is_jump;
   logic [WORD_W-1:0]    d_rs_data, d_rt_data;
   logic                 stall;
   logic                 bubble;
   // Execute
   lc4_insn_u            x_insn;
   logic [WORD_W-1:0]    x_pc;
   logic [WORD_W-1:0]    x_rs_data, x_rt_data;   // As read in decode
   logic [WORD_W-1:0]    x_rs_op, x_rt_op;       // After bypass
   logic [REG_SEL_W-1:0] x_rs_sel, x_rt_sel, x_rd_sel;
   logic                 x_regfile_we, x_nzp_we, x_is_load, x_is_store;
   logic                 x_is_branch, x_is_jump;
   logic [1:0]           rs_byp, rt_byp;
   logic [WORD_W-1:0]    x_alu;
   logic [2:0]           nzp;
   logic [2:0]           nzp_next;
   logic                 branch_taken;
   // Memory
   logic [WORD_W-1:0]    m_alu;
   logic [WORD_W-1:0]    m_rt_data;
   logic [WORD_W-1:0]    store_data;
   logic [REG_SEL_W-1:0] m_rd_sel, m_rt_sel;
   logic                 m_regfile_we, m_is_load, m_is_store;
   logic                 store_byp;
   // Writeback
   logic [WORD_W-1:0]    w_alu, w_load_data, w_wdata;
   logic [REG_SEL_W-1:0] w_rd_sel;
   logic                 w_regfile_we, w_is_load;

   // ============================================================
   // Fetch
   // ============================================================
   assign pc_we    = !stall || branch_taken;         // Redirect beats stall
   assign next_pc  = branch_taken ? x_alu : pc + 16'd1;
   assign o_cur_pc = pc;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc <= RESET_PC;
      end else if (pc_we) begin
         pc <= next_pc;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_rst_n || branch_taken) begin
         d_insn <= NOP_INSN;                          // Squash younger insn
      end else if (!stall) begin
         d_insn <= i_cur_insn;
      end
   end

   always_ff @(posedge gwe) begin
      if (!stall) begin
         d_pc <= pc;
      end
   end

   // ============================================================
   // Decode
   // ============================================================
   lc4_decoder decoder_i (
      .i_insn(d_insn), .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(d_rd_sel),
      .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_regfile_we(d_regfile_we),
      .o_nzp_we(d_nzp_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
      .o_is_branch(d_is_branch), .o_is_jump(d_is_jump));

   lc4_regfile regfile_i (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_rs_sel), .i_rt(d_rt_sel),
      .i_rd(w_rd_sel), .i_wdata(w_wdata), .i_rd_we(w_regfile_we),   // WD inside
      .o_rs_data(d_rs_data), .o_rt_data(d_rt_data));

   lc4_hazard_unit hazard_i (
      .i_d_rs_sel(d_rs_sel), .i_d_rt_sel(d_rt_sel), .i_d_rs_re(d_rs_re),
      .i_d_rt_re(d_rt_re), .i_d_is_store(d_is_store),
      .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel), .i_x_rd_sel(x_rd_sel),
      .i_x_is_load(x_is_load), .i_m_rd_sel(m_rd_sel), .i_m_rt_sel(m_rt_sel),
      .i_m_regfile_we(m_regfile_we), .i_w_rd_sel(w_rd_sel),
      .i_w_regfile_we(w_regfile_we), .o_stall(stall), .o_rs_byp(rs_byp),
      .o_rt_byp(rt_byp), .o_store_byp(store_byp));

   assign bubble = stall || branch_taken;            // NOP into execute

   always_ff @(posedge gwe) begin
      if (!i_rst_n || bubble) begin
         x_insn       <= NOP_INSN;
         x_regfile_we <= 1'b0;
         x_nzp_we     <= 1'b0;
         x_is_load    <= 1'b0;
         x_is_store   <= 1'b0;
         x_is_branch  <= 1'b0;
         x_is_jump    <= 1'b0;
      end else begin
         x_insn       <= d_insn;
         x_regfile_we <= d_regfile_we;
         x_nzp_we     <= d_nzp_we;
         x_is_load    <= d_is_load;
         x_is_store   <= d_is_store;
         x_is_branch  <= d_is_branch;
         x_is_jump    <= d_is_jump;
      end
   end

   always_ff @(posedge gwe) begin
      x_pc      <= d_pc;
      x_rs_data <= d_rs_data;
      x_rt_data <= d_rt_data;
      x_rs_sel  <= d_rs_sel;
      x_rt_sel  <= d_rt_sel;
      x_rd_sel  <= d_rd_sel;
   end

   // ============================================================
   // Execute
   // ============================================================
   always_comb begin
      case (rs_byp)
         BYP_MX:  x_rs_op = m_alu;
         BYP_WX:  x_rs_op = w_wdata;
         default: x_rs_op = x_rs_data;
      endcase
      case (rt_byp)
         BYP_MX:  x_rt_op = m_alu;
         BYP_WX:  x_rt_op = w_wdata;
         default: x_rt_op = x_rt_data;
      endcase
   end

   lc4_alu alu_i (
      .i_insn(x_insn), .i_pc(x_pc), .i_rs_data(x_rs_op), .i_rt_data(x_rt_op),
      .o_result(x_alu));

   // N, Z, P from the result
   assign nzp_next = x_alu[WORD_W-1] ? 3'b100 : (x_alu == '0) ? 3'b010 : 3'b001;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp <= 3'b000;                               // No branch taken yet
      end else if (x_nzp_we) begin
         nzp <= nzp_next;
      end
   end

   assign branch_taken = (x_is_branch && |(x_insn.br_fmt.nzp & nzp)) || x_is_jump;

   // ============================================================
   // Memory and writeback
   // ============================================================
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_regfile_we <= 1'b0;
         m_is_load    <= 1'b0;
         m_is_store   <= 1'b0;
         w_regfile_we <= 1'b0;
         w_is_load    <= 1'b0;
      end else begin
         m_regfile_we <= x_regfile_we;
         m_is_load    <= x_is_load;
         m_is_store   <= x_is_store;
         w_regfile_we <= m_regfile_we;
         w_is_load    <= m_is_load;
      end
   end

   always_ff @(posedge gwe) begin
      m_alu       <= x_alu;
      m_rt_data   <= x_rt_op;                         // Store data, MX or WX applied
      m_rd_sel    <= x_rd_sel;
      m_rt_sel    <= x_rt_sel;
      w_alu       <= m_alu;
      w_load_data <= i_cur_dmem_data;
      w_rd_sel    <= m_rd_sel;
   end

   assign store_data     = store_byp ? w_wdata : m_rt_data;   // WM
   assign o_dmem_we      = m_is_store;
   assign o_dmem_addr    = (m_is_load || m_is_store) ? m_alu : '0;
   assign o_dmem_towrite = m_is_store ? store_data : '0;

   assign w_wdata = w_is_load ? w_load_data : w_alu;

endmodule

// File: hdl/lc4_hazard_unit.sv
// ============================================================
// LC4 hazard unit
// Load-use stall and MX, WX, WM bypass selection
// ============================================================
`timescale 1ns/100ps

module lc4_hazard_unit
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic [REG_SEL_W-1:0] i_d_rs_sel,
   input  logic [REG_SEL_W-1:0] i_d_rt_sel,
   input  logic                 i_d_rs_re,
   input  logic                 i_d_rt_re,
   input  logic                 i_d_is_store,
   input  logic [REG_SEL_W-1:0] i_x_rs_sel,
   input  logic [REG_SEL_W-1:0] i_x_rt_sel,
   input  logic [REG_SEL_W-1:0] i_x_rd_sel,
   input  logic                 i_x_is_load,
   input  logic [REG_SEL_W-1:0] i_m_rd_sel,
   input  logic [REG_SEL_W-1:0] i_m_rt_sel,
   input  logic                 i_m_regfile_we,
   input  logic [REG_SEL_W-1:0] i_w_rd_sel,
   input  logic                 i_w_regfile_we,
   output logic                 o_stall,
   output logic [1:0]           o_rs_byp,
   output logic [1:0]           o_rt_byp,
   output logic                 o_store_byp
);

   logic rs_dep;
   logic rt_dep;

   // Youngest producer wins
   function automatic logic [1:0] byp_sel(input logic [REG_SEL_W-1:0] src,
                                          input logic [REG_SEL_W-1:0] m_rd,
                                          input logic                 m_we,
                                          input logic [REG_SEL_W-1:0] w_rd,
                                          input logic                 w_we);
      logic [1:0] sel;
      sel = BYP_NONE;
      if (m_we && m_rd == src) begin
         sel = BYP_MX;
      end else if (w_we && w_rd == src) begin
         sel = BYP_WX;
      end
      return sel;
   endfunction

   // ============================================================
   // Load-use
   // ============================================================
   assign rs_dep  = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
   assign rt_dep  = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);  // WM covers
   assign o_stall = i_x_is_load && (rs_dep || rt_dep);

   // ============================================================
   // Bypass selects
   // ============================================================
   assign o_rs_byp = byp_sel(i_x_rs_sel, i_m_rd_sel, i_m_regfile_we,
                             i_w_rd_sel, i_w_regfile_we);
   assign o_rt_byp = byp_sel(i_x_rt_sel, i_m_rd_sel, i_m_regfile_we,
                             i_w_rd_sel, i_w_regfile_we);

   assign o_store_byp = i_w_regfile_we && (i_m_rt_sel == i_w_rd_sel);  // Store data from W

endmodule

// File: hdl/lc4_alu.sv
// ============================================================
// LC4 ALU
// Arithmetic, CONST, memory address and control targets
// ============================================================
`timescale 1ns/100ps

module lc4_alu
   import lc4_isa_pkg::*;
(
   input  lc4_insn_u         i_insn,
   input  logic [WORD_W-1:0] i_pc,
   input  logic [WORD_W-1:0] i_rs_data,
   input  logic [WORD_W-1:0] i_rt_data,
   output logic [WORD_W-1:0] o_result
);

   logic [WORD_W-1:0] imm5_sx;
   logic [WORD_W-1:0] imm6_sx;
   logic [WORD_W-1:0] imm9_sx;
   logic [WORD_W-1:0] imm11_sx;
   logic [WORD_W-1:0] pc_inc;
   logic [10:0]       imm11;

   // ADDi immediate spans sub[1:0] and rt
   assign imm5_sx = {{(WORD_W-5){i_insn.r_fmt.sub[1]}},
                     i_insn.r_fmt.sub[1:0], i_insn.r_fmt.rt};
   assign imm6_sx = {{(WORD_W-6){i_insn.mem_fmt.imm6[5]}}, i_insn.mem_fmt.imm6};
   assign imm9_sx = {{(WORD_W-9){i_insn.br_fmt.imm9[8]}}, i_insn.br_fmt.imm9};

   // JMP offset borrows the low mask bits
   assign imm11    = {i_insn.br_fmt.nzp[1:0], i_insn.br_fmt.imm9};
   assign imm11_sx = {{(WORD_W-11){imm11[10]}}, imm11};

   assign pc_inc = i_pc + 16'd1;

   always_comb begin
      o_result = '0;
      case (i_insn.r_fmt.opcode)
         OPC_BR:    o_result = pc_inc + imm9_sx;  // Branch target
         OPC_ARITH: begin
            if (i_insn.r_fmt.sub[2]) begin
               o_result = i_rs_data + imm5_sx;    // ADDi
            end else if (i_insn.r_fmt.sub == SUB_ADD) begin
               o_result = i_rs_data + i_rt_data;
            end else if (i_insn.r_fmt.sub == SUB_SUB) begin
               o_result = i_rs_data - i_rt_data;
            end
         end
         OPC_LDR,
         OPC_STR:   o_result = i_rs_data + imm6_sx;  // Effective address
         OPC_CONST: o_result = imm9_sx;
         OPC_JMP:   o_result = pc_inc + imm11_sx;
         default:   o_result = '0;
      endcase
   end

endmodule

// File: hdl/lc4_regfile.sv
// ============================================================
// LC4 register file
// 8 x 16, two read ports, one write port, WD bypass
// ============================================================
`timescale 1ns/100ps

module lc4_regfile
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_rst_n,
   input  logic [REG_SEL_W-1:0] i_rs,
   input  logic [REG_SEL_W-1:0] i_rt,
   input  logic [REG_SEL_W-1:0] i_rd,
   input  logic [WORD_W-1:0]    i_wdata,
   input  logic                 i_rd_we,
   output logic [WORD_W-1:0]    o_rs_data,
   output logic [WORD_W-1:0]    o_rt_data
);

   logic [WORD_W-1:0] regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Same-cycle write seen by the reader
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: hdl/lc4_decoder.sv
// ============================================================
// LC4 decoder
// Register selects and control flags from one instruction
// ============================================================
`timescale 1ns/100ps

module lc4_decoder
   import lc4_isa_pkg::*;
(
   input  lc4_insn_u            i_insn,
   output logic [REG_SEL_W-1:0] o_rs_sel,
   output logic [REG_SEL_W-1:0] o_rt_sel,
   output logic [REG_SEL_W-1:0] o_rd_sel,
   output logic                 o_rs_re,
   output logic                 o_rt_re,
   output logic                 o_regfile_we,
   output logic                 o_nzp_we,
   output logic                 o_is_load,
   output logic                 o_is_store,
   output logic                 o_is_branch,
   output logic                 o_is_jump
);

   // Field positions shared by every kept format
   assign o_rs_sel = i_insn.r_fmt.rs;
   assign o_rd_sel = i_insn.r_fmt.rd;        // CONST rd lands here too
   assign o_rt_sel = (i_insn.mem_fmt.opcode == OPC_STR) ? i_insn.mem_fmt.rd :
                                                          i_insn.r_fmt.rt;

   always_comb begin
      o_rs_re      = 1'b0;
      o_rt_re      = 1'b0;
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_is_branch  = 1'b0;
      o_is_jump    = 1'b0;
      case (i_insn.r_fmt.opcode)
         OPC_BR:    o_is_branch = 1'b1;      // Empty mask never taken
         OPC_ARITH: begin
            if (i_insn.r_fmt.sub[2]) begin   // ADDi
               o_rs_re      = 1'b1;
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end else if (i_insn.r_fmt.sub == SUB_ADD || i_insn.r_fmt.sub == SUB_SUB) begin
               o_rs_re      = 1'b1;
               o_rt_re      = 1'b1;
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end
         end
         OPC_LDR: begin
            o_rs_re      = 1'b1;
            o_regfile_we = 1'b1;
            o_is_load    = 1'b1;             // No NZP update
         end
         OPC_STR: begin
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;               // Store data
            o_is_store = 1'b1;
         end
         OPC_CONST: begin
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         OPC_JMP:   o_is_jump = i_insn.br_fmt.nzp[2];  // Bit 11 clear is JMPR
         default:   ;                        // Treated as NOP
      endcase
   end

endmodule

// File: hdl/lc4_pipe_pkg.sv
// ============================================================
// LC4 pipeline constants
// Reset PC, bubble word, register count, bypass codes
// ============================================================
package lc4_pipe_pkg;

   localparam logic [15:0] RESET_PC = 16'h8200;  // Boot address
   localparam logic [15:0] NOP_INSN = 16'h0000;  // BR, empty mask

   localparam int NUM_REGS = 8;

   // ALU operand source
   localparam logic [1:0] BYP_NONE = 2'd0;  // Value read in decode
   localparam logic [1:0] BYP_MX   = 2'd1;  // Memory-stage ALU result
   localparam logic [1:0] BYP_WX   = 2'd2;  // Writeback data

endpackage

// File: hdl/lc4_isa_pkg.sv
// ============================================================
// LC4 instruction set definitions
// Opcodes, field widths and the views of one instruction word
// ============================================================
package lc4_isa_pkg;

   localparam int WORD_W    = 16;  // Machine word
   localparam int REG_SEL_W = 3;   // r0..r7
   localparam int OPC_W     = 4;   // Bits 15:12

   // Major opcodes
   localparam logic [OPC_W-1:0] OPC_BR    = 4'b0000;  // Also NOP with empty mask
   localparam logic [OPC_W-1:0] OPC_ARITH = 4'b0001;
   localparam logic [OPC_W-1:0] OPC_LDR   = 4'b0110;
   localparam logic [OPC_W-1:0] OPC_STR   = 4'b0111;
   localparam logic [OPC_W-1:0] OPC_CONST = 4'b1001;
   localparam logic [OPC_W-1:0] OPC_JMP   = 4'b1100;  // Needs bit 11 set

   // Arithmetic sub-codes in bits 5:3
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;

   // One word, three ways of reading it
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0]     opcode;
         logic [REG_SEL_W-1:0] rd;
         logic [REG_SEL_W-1:0] rs;
         logic [2:0]           sub;     // MSB set for ADDi
         logic [REG_SEL_W-1:0] rt;      // Low imm5 bits for ADDi
      } r_fmt;
      struct packed {
         logic [OPC_W-1:0]     opcode;
         logic [2:0]           nzp;     // Branch mask
         logic [8:0]           imm9;
      } br_fmt;
      struct packed {
         logic [OPC_W-1:0]     opcode;
         logic [REG_SEL_W-1:0] rd;      // rt for STR
         logic [REG_SEL_W-1:0] rs;      // Base register
         logic [5:0]           imm6;
      } mem_fmt;
   } lc4_insn_u;

   // CONST keeps its rd in the nzp slot of br_fmt
   // JMP spreads imm11 over nzp[1:0] and imm9

endpackage
